// File: src/axi_defs_pkg.sv
// ================================================
// AXI4 field widths and response codes
// strobe width assumes byte lanes over the data bus
// ================================================
package axi_defs_pkg;

  localparam int AXI_ID_WIDTH   = 8;
  localparam int AXI_USER_WIDTH = 4;
  localparam int AXI_ADDR_WIDTH = 32;
  localparam int AXI_DATA_WIDTH = 32;
  localparam int AXI_STRB_WIDTH = AXI_DATA_WIDTH / 8;

  // only the two codes that the filter ever returns by itself
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

// File: src/remap_pkg.sv
// ================================================
// region table and drop queue sizing
// META_FIFO_DEPTH must stay a power of two
// ================================================
package remap_pkg;

  localparam int NUM_REGIONS      = 4;
  localparam int REGION_IDX_WIDTH = 2;

  // drops that may wait for their injected responses
  localparam int META_FIFO_DEPTH = 4;
  localparam int META_PTR_WIDTH  = 2;

  // what the B sender needs to build a response for a discarded write
  typedef struct packed {
    logic                                prefetch;
    logic                                hit;
    logic [axi_defs_pkg::AXI_ID_WIDTH-1:0] id;
  } drop_meta_t;

endpackage

// File: src/axi_b_if.sv
// ================================================
// AXI4 write response channel
// user width follows the shared AXI definitions
// ================================================
`timescale 1ns/1ps

interface axi_b_if
  import axi_defs_pkg::*;
();

  logic [AXI_ID_WIDTH-1:0]   bid;
  logic [1:0]                bresp;
  logic [AXI_USER_WIDTH-1:0] buser;
  logic                      bvalid;
  logic                      bready;

  // the side that produces responses
  modport sender (output bid, bresp, buser, bvalid, input bready);

  // the side that consumes responses
  modport receiver (input bid, bresp, buser, bvalid, output bready);

endinterface

// File: src/region_table.sv
// ================================================
// four software-written regions, all invalid after reset
// base and last are inclusive; overlaps favour writable
// ================================================
`timescale 1ns/1ps

module region_table
  import axi_defs_pkg::*;
  import remap_pkg::*;
(
  input  logic                        axi4_aclk,
  input  logic                        axi4_arstn,
  input  logic                        cfg_we_i,
  input  logic [REGION_IDX_WIDTH-1:0] cfg_idx_i,
  input  logic [AXI_ADDR_WIDTH-1:0]   cfg_base_i,
  input  logic [AXI_ADDR_WIDTH-1:0]   cfg_last_i,
  input  logic                        cfg_valid_i,
  input  logic                        cfg_writable_i,
  input  logic [AXI_ADDR_WIDTH-1:0]   lookup_addr_i,
  output logic                        region_hit_o,
  output logic                        region_allow_o
);

  logic [AXI_ADDR_WIDTH-1:0] base_q [NUM_REGIONS];
  logic [AXI_ADDR_WIDTH-1:0] last_q [NUM_REGIONS];
  logic [NUM_REGIONS-1:0]    valid_q;
  logic [NUM_REGIONS-1:0]    writable_q;
  logic [NUM_REGIONS-1:0]    match;

  always_ff @(posedge axi4_aclk or negedge axi4_arstn) begin
    if (!axi4_arstn) begin
      valid_q    <= '0;
      writable_q <= '0;
    end else if (cfg_we_i) begin
      valid_q[cfg_idx_i]    <= cfg_valid_i;
      writable_q[cfg_idx_i] <= cfg_writable_i;
    end
  end

  always_ff @(posedge axi4_aclk) begin
    if (cfg_we_i) begin
      base_q[cfg_idx_i] <= cfg_base_i;
      last_q[cfg_idx_i] <= cfg_last_i;
    end
  end

  always_comb begin
    for (int i = 0; i < NUM_REGIONS; i++) begin
      match[i] = valid_q[i] && (lookup_addr_i >= base_q[i]) &&
                 (lookup_addr_i <= last_q[i]);
    end
  end

  // a single writable match is enough to let the write through
  assign region_allow_o = |(match & writable_q);
  assign region_hit_o   = (|match) && !region_allow_o;

endmodule

// File: src/write_filter.sv
// ================================================
// single-beat writes only, one write in flight at a time
// the region decision is frozen one cycle after AW is taken
// ================================================
`timescale 1ns/1ps

module write_filter
  import axi_defs_pkg::*;
  import remap_pkg::*;
(
  input  logic                      axi4_aclk,
  input  logic                      axi4_arstn,
  input  logic [AXI_ID_WIDTH-1:0]   s_awid_i,
  input  logic [AXI_ADDR_WIDTH-1:0] s_awaddr_i,
  input  logic [AXI_USER_WIDTH-1:0] s_awuser_i,
  input  logic                      s_awvalid_i,
  output logic                      s_awready_o,
  input  logic [AXI_DATA_WIDTH-1:0] s_wdata_i,
  input  logic [AXI_STRB_WIDTH-1:0] s_wstrb_i,
  input  logic                      s_wvalid_i,
  output logic                      s_wready_o,
  output logic [AXI_ID_WIDTH-1:0]   m_awid_o,
  output logic [AXI_ADDR_WIDTH-1:0] m_awaddr_o,
  output logic [AXI_USER_WIDTH-1:0] m_awuser_o,
  output logic                      m_awvalid_o,
  input  logic                      m_awready_i,
  output logic [AXI_DATA_WIDTH-1:0] m_wdata_o,
  output logic [AXI_STRB_WIDTH-1:0] m_wstrb_o,
  output logic                      m_wvalid_o,
  input  logic                      m_wready_i,
  output logic [AXI_ADDR_WIDTH-1:0] lookup_addr_o,
  input  logic                      region_hit_i,
  input  logic                      region_allow_i,
  output logic                      drop_o,
  output drop_meta_t                drop_meta_o,
  input  logic                      done_i
);

  logic                      init_q;
  logic                      full_q;
  logic                      w_have_q;
  logic                      aw_sent_q;
  logic                      w_sent_q;
  logic                      dec_q;
  logic                      allow_q;
  logic                      hit_q;
  logic [AXI_ID_WIDTH-1:0]   awid_q;
  logic [AXI_ADDR_WIDTH-1:0] awaddr_q;
  logic [AXI_USER_WIDTH-1:0] awuser_q;
  logic [AXI_DATA_WIDTH-1:0] wdata_q;
  logic [AXI_STRB_WIDTH-1:0] wstrb_q;
  logic                      allow;
  logic                      hit;
  logic                      aw_take;
  logic                      w_take;
  logic                      m_aw_hs;
  logic                      m_w_hs;
  logic                      fwd_done;
  logic                      retire;

  // live lookup in the first held cycle, frozen copy afterwards so that a
  // reconfiguration cannot split one write between forward and drop
  assign allow = dec_q ? allow_q : region_allow_i;
  assign hit   = dec_q ? hit_q : region_hit_i;

  // init_q keeps both readies low until the first cycle after reset release
  assign s_awready_o = init_q & ~full_q;
  assign s_wready_o  = init_q & ~w_have_q;
  assign aw_take     = s_awvalid_i & s_awready_o;
  assign w_take      = s_wvalid_i & s_wready_o;

  assign m_awvalid_o = full_q & allow & ~aw_sent_q;
  assign m_wvalid_o  = full_q & w_have_q & allow & ~w_sent_q;
  assign m_aw_hs     = m_awvalid_o & m_awready_i;
  assign m_w_hs      = m_wvalid_o & m_wready_i;
  assign fwd_done    = full_q & allow & (aw_sent_q | m_aw_hs) & (w_sent_q | m_w_hs);

  // a denied write only asks for a drop once its data beat is drained
  assign drop_o      = full_q & w_have_q & ~allow;
  assign retire      = fwd_done | (drop_o & done_i);

  assign drop_meta_o   = '{prefetch: awuser_q[0], hit: hit, id: awid_q};
  assign lookup_addr_o = awaddr_q;
  assign m_awid_o      = awid_q;
  assign m_awaddr_o    = awaddr_q;
  assign m_awuser_o    = awuser_q;
  assign m_wdata_o     = wdata_q;
  assign m_wstrb_o     = wstrb_q;

  always_ff @(posedge axi4_aclk or negedge axi4_arstn) begin
    if (!axi4_arstn) begin
      init_q    <= 1'b0;
      full_q    <= 1'b0;
      w_have_q  <= 1'b0;
      aw_sent_q <= 1'b0;
      w_sent_q  <= 1'b0;
      dec_q     <= 1'b0;
    end else begin
      init_q <= 1'b1;
      if (retire) begin
        full_q    <= 1'b0;
        w_have_q  <= 1'b0;
        aw_sent_q <= 1'b0;
        w_sent_q  <= 1'b0;
        dec_q     <= 1'b0;
      end else begin
        if (aw_take) full_q <= 1'b1;
        if (w_take) w_have_q <= 1'b1;
        if (full_q) dec_q <= 1'b1;
        if (m_aw_hs) aw_sent_q <= 1'b1;
        if (m_w_hs) w_sent_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge axi4_aclk) begin
    if (aw_take) begin
      awid_q   <= s_awid_i;
      awaddr_q <= s_awaddr_i;
      awuser_q <= s_awuser_i;
    end
    if (w_take) begin
      wdata_q <= s_wdata_i;
      wstrb_q <= s_wstrb_i;
    end
    if (full_q && !dec_q) begin
      allow_q <= region_allow_i;
      hit_q   <= region_hit_i;
    end
  end

endmodule

// File: src/meta_fifo.sv
// ================================================
// drop metadata queue, pushes while full are ignored
// new data shows on the output one cycle after the push
// ================================================
`timescale 1ns/1ps

module meta_fifo
  import remap_pkg::*;
(
  input  logic       axi4_aclk,
  input  logic       axi4_arstn,
  input  logic       push_i,
  input  drop_meta_t push_data_i,
  input  logic       pop_i,
  output logic       full_o,
  output logic       empty_o,
  output drop_meta_t pop_data_o
);

  drop_meta_t                mem_q [META_FIFO_DEPTH];
  logic [META_PTR_WIDTH-1:0] wr_ptr_q;
  logic [META_PTR_WIDTH-1:0] rd_ptr_q;
  logic [META_PTR_WIDTH:0]   count_q;
  logic                      do_push;
  logic                      do_pop;

  assign full_o  = (count_q == (META_PTR_WIDTH + 1)'(META_FIFO_DEPTH));
  assign empty_o = (count_q == '0);
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  always_ff @(posedge axi4_aclk or negedge axi4_arstn) begin
    if (!axi4_arstn) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // pointers wrap on their own since the depth is a power of two
      if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (do_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge axi4_aclk) begin
    if (do_push) mem_q[wr_ptr_q] <= push_data_i;
  end

  assign pop_data_o = mem_q[rd_ptr_q];

endmodule

// File: src/axi4_b_sender.sv
// ================================================
// injected responses win over downstream ones, but never
// cut into a downstream response that is already stalled
// ================================================
`timescale 1ns/1ps

module axi4_b_sender
  import axi_defs_pkg::*;
  import remap_pkg::*;
(
  input  logic       axi4_aclk,
  input  logic       axi4_arstn,
  input  logic       drop_i,
  input  drop_meta_t drop_meta_i,
  output logic       done_o,
  axi_b_if.sender    s_b,
  axi_b_if.receiver  m_b
);

  drop_meta_t head;
  logic       fifo_full;
  logic       fifo_empty;
  logic       fifo_pop;
  logic       injecting_q;
  logic       m_b_stalled;

  meta_fifo u_meta_fifo (
    .axi4_aclk   (axi4_aclk),
    .axi4_arstn  (axi4_arstn),
    .push_i      (done_o),
    .push_data_i (drop_meta_i),
    .pop_i       (fifo_pop),
    .full_o      (fifo_full),
    .empty_o     (fifo_empty),
    .pop_data_o  (head)
  );

  // the drop is taken exactly when it can be queued
  assign done_o   = drop_i & ~fifo_full;
  assign fifo_pop = injecting_q & s_b.bready;

  // a downstream response waiting on bready must finish before we take over
  assign m_b_stalled = m_b.bvalid & ~s_b.bready;

  always_ff @(posedge axi4_aclk or negedge axi4_arstn) begin
    if (!axi4_arstn) begin
      injecting_q <= 1'b0;
    end else if (!injecting_q && !fifo_empty && !m_b_stalled) begin
      injecting_q <= 1'b1;
    end else if (fifo_pop) begin
      injecting_q <= 1'b0;
    end
  end

  assign s_b.bid    = injecting_q ? head.id : m_b.bid;
  assign s_b.buser  = injecting_q ? '0 : m_b.buser;
  assign s_b.bvalid = injecting_q | m_b.bvalid;

  // only a prefetch into a read-only region is quietly acknowledged
  assign s_b.bresp = !injecting_q ? m_b.bresp :
                     (head.prefetch && head.hit) ? RESP_OKAY : RESP_SLVERR;

  assign m_b.bready = ~injecting_q & s_b.bready;

endmodule

// File: src/wr_remap_top.sv
// ================================================
// write path of the remapping filter, awlen 0 and wlast 1
// no read path; regions are set through the cfg_ port
// ================================================
`timescale 1ns/1ps

module wr_remap_top
  import axi_defs_pkg::*;
  import remap_pkg::*;
(
  input  logic                        axi4_aclk,
  input  logic                        axi4_arstn,
  // upstream slave port
  input  logic [AXI_ID_WIDTH-1:0]     s_awid_i,
  input  logic [AXI_ADDR_WIDTH-1:0]   s_awaddr_i,
  input  logic [AXI_USER_WIDTH-1:0]   s_awuser_i,
  input  logic                        s_awvalid_i,
  output logic                        s_awready_o,
  input  logic [AXI_DATA_WIDTH-1:0]   s_wdata_i,
  input  logic [AXI_STRB_WIDTH-1:0]   s_wstrb_i,
  input  logic                        s_wvalid_i,
  output logic                        s_wready_o,
  output logic [AXI_ID_WIDTH-1:0]     s_bid_o,
  output logic [1:0]                  s_bresp_o,
  output logic [AXI_USER_WIDTH-1:0]   s_buser_o,
  output logic                        s_bvalid_o,
  input  logic                        s_bready_i,
  // downstream master port
  output logic [AXI_ID_WIDTH-1:0]     m_awid_o,
  output logic [AXI_ADDR_WIDTH-1:0]   m_awaddr_o,
  output logic [AXI_USER_WIDTH-1:0]   m_awuser_o,
  output logic                        m_awvalid_o,
  input  logic                        m_awready_i,
  output logic [AXI_DATA_WIDTH-1:0]   m_wdata_o,
  output logic [AXI_STRB_WIDTH-1:0]   m_wstrb_o,
  output logic                        m_wvalid_o,
  input  logic                        m_wready_i,
  input  logic [AXI_ID_WIDTH-1:0]     m_bid_i,
  input  logic [1:0]                  m_bresp_i,
  input  logic [AXI_USER_WIDTH-1:0]   m_buser_i,
  input  logic                        m_bvalid_i,
  output logic                        m_bready_o,
  // region configuration
  input  logic                        cfg_we_i,
  input  logic [REGION_IDX_WIDTH-1:0] cfg_idx_i,
  input  logic [AXI_ADDR_WIDTH-1:0]   cfg_base_i,
  input  logic [AXI_ADDR_WIDTH-1:0]   cfg_last_i,
  input  logic                        cfg_valid_i,
  input  logic                        cfg_writable_i
);

  logic                      region_hit;
  logic                      region_allow;
  logic [AXI_ADDR_WIDTH-1:0] lookup_addr;
  logic                      drop;
  logic                      done;
  drop_meta_t                drop_meta;

  axi_b_if s_b_bus ();
  axi_b_if m_b_bus ();

  assign m_b_bus.bid    = m_bid_i;
  assign m_b_bus.bresp  = m_bresp_i;
  assign m_b_bus.buser  = m_buser_i;
  assign m_b_bus.bvalid = m_bvalid_i;
  assign m_bready_o     = m_b_bus.bready;

  assign s_bid_o        = s_b_bus.bid;
  assign s_bresp_o      = s_b_bus.bresp;
  assign s_buser_o      = s_b_bus.buser;
  assign s_bvalid_o     = s_b_bus.bvalid;
  assign s_b_bus.bready = s_bready_i;

  region_table u_region_table (
    .axi4_aclk      (axi4_aclk),
    .axi4_arstn     (axi4_arstn),
    .cfg_we_i       (cfg_we_i),
    .cfg_idx_i      (cfg_idx_i),
    .cfg_base_i     (cfg_base_i),
    .cfg_last_i     (cfg_last_i),
    .cfg_valid_i    (cfg_valid_i),
    .cfg_writable_i (cfg_writable_i),
    .lookup_addr_i  (lookup_addr),
    .region_hit_o   (region_hit),
    .region_allow_o (region_allow)
  );

  write_filter u_write_filter (
    .axi4_aclk      (axi4_aclk),
    .axi4_arstn     (axi4_arstn),
    .s_awid_i       (s_awid_i),
    .s_awaddr_i     (s_awaddr_i),
    .s_awuser_i     (s_awuser_i),
    .s_awvalid_i    (s_awvalid_i),
    .s_awready_o    (s_awready_o),
    .s_wdata_i      (s_wdata_i),
    .s_wstrb_i      (s_wstrb_i),
    .s_wvalid_i     (s_wvalid_i),
    .s_wready_o     (s_wready_o),
    .m_awid_o       (m_awid_o),
    .m_awaddr_o     (m_awaddr_o),
    .m_awuser_o     (m_awuser_o),
    .m_awvalid_o    (m_awvalid_o),
    .m_awready_i    (m_awready_i),
    .m_wdata_o      (m_wdata_o),
    .m_wstrb_o      (m_wstrb_o),
    .m_wvalid_o     (m_wvalid_o),
    .m_wready_i     (m_wready_i),
    .lookup_addr_o  (lookup_addr),
    .region_hit_i   (region_hit),
    .region_allow_i (region_allow),
    .drop_o         (drop),
    .drop_meta_o    (drop_meta),
    .done_i         (done)
  );

  axi4_b_sender u_b_sender (
    .axi4_aclk   (axi4_aclk),
    .axi4_arstn  (axi4_arstn),
    .drop_i      (drop),
    .drop_meta_i (drop_meta),
    .done_o      (done),
    .s_b         (s_b_bus.sender),
    .m_b         (m_b_bus.receiver)
  );

endmodule

// File: test/b_sender_chk.sv
// ================================================
// B-channel and drop handshake rules of the response merger
// bound into axi4_b_sender and reads its injecting_q
// ================================================
`timescale 1ns/1ps

module b_sender_chk
  import axi_defs_pkg::*;
  import remap_pkg::*;
(
  input logic                    axi4_aclk,
  input logic                    axi4_arstn,
  input logic                    injecting_i,
  input logic                    drop_i,
  input drop_meta_t              drop_meta_i,
  input logic                    done_i,
  input logic                    s_bvalid_i,
  input logic                    s_bready_i,
  input logic [AXI_ID_WIDTH-1:0] s_bid_i,
  input logic [1:0]              s_bresp_i,
  input logic                    m_bvalid_i,
  input logic                    m_bready_i,
  input logic [AXI_ID_WIDTH-1:0] m_bid_i,
  input logic [1:0]              m_bresp_i
);

  int fail_count = 0;

  // an offered response stays put until upstream takes it
  a_b_hold : assert property (@(posedge axi4_aclk) disable iff (!axi4_arstn)
    s_bvalid_i && !s_bready_i |=> s_bvalid_i && $stable(s_bid_i) && $stable(s_bresp_i))
  else begin
    $error("upstream B response changed or vanished before bready");
    fail_count = fail_count + 1;
  end

  // a downstream response is only consumed while it is passed upstream unchanged
  a_pass_through : assert property (@(posedge axi4_aclk) disable iff (!axi4_arstn)
    m_bvalid_i && m_bready_i |->
      s_bvalid_i && s_bready_i && !injecting_i &&
      (s_bid_i == m_bid_i) && (s_bresp_i == m_bresp_i))
  else begin
    $error("downstream B response consumed without reaching the upstream port");
    fail_count = fail_count + 1;
  end

  // a drop that is not yet taken waits with the same metadata
  a_drop_held : assert property (@(posedge axi4_aclk) disable iff (!axi4_arstn)
    drop_i && !done_i |=> drop_i && $stable(drop_meta_i))
  else begin
    $error("drop request withdrawn or changed before done");
    fail_count = fail_count + 1;
  end

endmodule

bind axi4_b_sender b_sender_chk u_chk (
  .axi4_aclk   (axi4_aclk),
  .axi4_arstn  (axi4_arstn),
  .injecting_i (injecting_q),
  .drop_i      (drop_i),
  .drop_meta_i (drop_meta_i),
  .done_i      (done_o),
  .s_bvalid_i  (s_b.bvalid),
  .s_bready_i  (s_b.bready),
  .s_bid_i     (s_b.bid),
  .s_bresp_i   (s_b.bresp),
  .m_bvalid_i  (m_b.bvalid),
  .m_bready_i  (m_b.bready),
  .m_bid_i     (m_b.bid),
  .m_bresp_i   (m_b.bresp)
);

// File: test/tb_wr_remap.sv
// ================================================
// directed tests of the write remapping filter
// downstream model takes every AW and W at once and answers after a random delay
// ================================================
`timescale 1ns/1ps

module tb_wr_remap
  import axi_defs_pkg::*;
  import remap_pkg::*;
;

  logic                        axi4_aclk;
  logic                        axi4_arstn;
  logic [AXI_ID_WIDTH-1:0]     s_awid_i;
  logic [AXI_ADDR_WIDTH-1:0]   s_awaddr_i;
  logic [AXI_USER_WIDTH-1:0]   s_awuser_i;
  logic                        s_awvalid_i;
  logic                        s_awready_o;
  logic [AXI_DATA_WIDTH-1:0]   s_wdata_i;
  logic [AXI_STRB_WIDTH-1:0]   s_wstrb_i;
  logic                        s_wvalid_i;
  logic                        s_wready_o;
  logic [AXI_ID_WIDTH-1:0]     s_bid_o;
  logic [1:0]                  s_bresp_o;
  logic [AXI_USER_WIDTH-1:0]   s_buser_o;
  logic                        s_bvalid_o;
  logic                        s_bready_i;
  logic [AXI_ID_WIDTH-1:0]     m_awid_o;
  logic [AXI_ADDR_WIDTH-1:0]   m_awaddr_o;
  logic [AXI_USER_WIDTH-1:0]   m_awuser_o;
  logic                        m_awvalid_o;
  logic                        m_awready_i;
  logic [AXI_DATA_WIDTH-1:0]   m_wdata_o;
  logic [AXI_STRB_WIDTH-1:0]   m_wstrb_o;
  logic                        m_wvalid_o;
  logic                        m_wready_i;
  logic [AXI_ID_WIDTH-1:0]     m_bid_i;
  logic [1:0]                  m_bresp_i;
  logic [AXI_USER_WIDTH-1:0]   m_buser_i;
  logic                        m_bvalid_i;
  logic                        m_bready_o;
  logic                        cfg_we_i;
  logic [REGION_IDX_WIDTH-1:0] cfg_idx_i;
  logic [AXI_ADDR_WIDTH-1:0]   cfg_base_i;
  logic [AXI_ADDR_WIDTH-1:0]   cfg_last_i;
  logic                        cfg_valid_i;
  logic                        cfg_writable_i;

  // reference copy of the region table
  logic [AXI_ADDR_WIDTH-1:0] ref_base [NUM_REGIONS];
  logic [AXI_ADDR_WIDTH-1:0] ref_last [NUM_REGIONS];
  logic [NUM_REGIONS-1:0]    ref_valid;
  logic [NUM_REGIONS-1:0]    ref_wr;

  // responses still owed upstream, and writes expected downstream
  logic [AXI_ID_WIDTH-1:0]   exp_id_q [$];
  logic [1:0]                exp_resp_q [$];
  logic [AXI_ID_WIDTH-1:0]   fwd_id_q [$];
  logic [AXI_ADDR_WIDTH-1:0] fwd_addr_q [$];
  logic [AXI_USER_WIDTH-1:0] fwd_user_q [$];
  logic [AXI_DATA_WIDTH-1:0] fwd_data_q [$];
  logic [AXI_STRB_WIDTH-1:0] fwd_strb_q [$];
  logic [AXI_ID_WIDTH-1:0]   pend_id_q [$];
  logic [AXI_ID_WIDTH-1:0]   next_bid;
  logic                      aw_seen;
  logic                      w_seen;
  int                        b_delay;
  int                        stretch;
  logic                      bp_mode;
  logic [31:0]               lcg_state = 32'h6524_4686;

  wr_remap_top uut (.*);

  always #5 axi4_aclk = ~axi4_aclk;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic stop_with_failure();
    $display("Some tests failed");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic report_mismatch(input string msg);
    $display("FAIL at %0t: %s", $time, msg);
    stop_with_failure();
  endtask

  task automatic abort_on_timeout(input string msg);
    $display("timeout, %s", msg);
    stop_with_failure();
  endtask

  // a writable match forwards, and a prefetch into a read-only region is acknowledged
  function automatic void predict(input logic [AXI_ADDR_WIDTH-1:0] addr, input logic prefetch,
                                  output logic fwd, output logic [1:0] resp);
    logic any_match;
    logic any_wr;
    any_match = 1'b0;
    any_wr = 1'b0;
    for (int i = 0; i < NUM_REGIONS; i++) begin
      if (ref_valid[i] && addr >= ref_base[i] && addr <= ref_last[i]) begin
        any_match = 1'b1;
        if (ref_wr[i])
          any_wr = 1'b1;
      end
    end
    fwd = any_wr;
    if (any_wr || (any_match && prefetch))
      resp = RESP_OKAY;
    else
      resp = RESP_SLVERR;
  endfunction

  task automatic configure_region(input int idx, input logic [31:0] base, input logic [31:0] last,
                                  input logic valid, input logic writable);
    @(posedge axi4_aclk);
    cfg_we_i       <= 1'b1;
    cfg_idx_i      <= REGION_IDX_WIDTH'(idx);
    cfg_base_i     <= base;
    cfg_last_i     <= last;
    cfg_valid_i    <= valid;
    cfg_writable_i <= writable;
    ref_base[idx]  = base;
    ref_last[idx]  = last;
    ref_valid[idx] = valid;
    ref_wr[idx]    = writable;
    @(posedge axi4_aclk);
    cfg_we_i <= 1'b0;
  endtask

  task automatic do_write(input logic [AXI_ID_WIDTH-1:0] id, input logic [31:0] addr,
                          input logic prefetch);
    logic [31:0]               data;
    logic [AXI_USER_WIDTH-1:0] user;
    logic [AXI_STRB_WIDTH-1:0] strb;
    logic                      fwd;
    logic [1:0]                resp;
    logic                      aw_done;
    logic                      w_done;
    int                        cycles;
    data = lcg_next();
    // the upper user bits carry no meaning and get random values
    user = data[AXI_USER_WIDTH+7:8];
    user[0] = prefetch;
    strb = data[AXI_STRB_WIDTH+15:16];
    predict(addr, prefetch, fwd, resp);
    exp_id_q.push_back(id);
    exp_resp_q.push_back(resp);
    if (fwd) begin
      fwd_id_q.push_back(id);
      fwd_addr_q.push_back(addr);
      fwd_user_q.push_back(user);
      fwd_data_q.push_back(data);
      fwd_strb_q.push_back(strb);
    end
    @(posedge axi4_aclk);
    s_awvalid_i <= 1'b1;
    s_awid_i    <= id;
    s_awaddr_i  <= addr;
    s_awuser_i  <= user;
    s_wvalid_i  <= 1'b1;
    s_wdata_i   <= data;
    s_wstrb_i   <= strb;
    aw_done = 1'b0;
    w_done = 1'b0;
    cycles = 0;
    while (!(aw_done && w_done)) begin
      @(posedge axi4_aclk);
      if (s_awvalid_i && s_awready_o) begin
        aw_done = 1'b1;
        s_awvalid_i <= 1'b0;
      end
      if (s_wvalid_i && s_wready_o) begin
        w_done = 1'b1;
        s_wvalid_i <= 1'b0;
      end
      cycles++;
      if (cycles > 300)
        abort_on_timeout($sformatf("write with id %0h was never accepted", id));
    end
  endtask

  task automatic wait_responses();
    int cycles;
    cycles = 0;
    while (exp_id_q.size() > 0) begin
      @(posedge axi4_aclk);
      cycles++;
      if (cycles > 3000)
        abort_on_timeout($sformatf("%0d write responses never arrived", exp_id_q.size()));
    end
    assert (fwd_id_q.size() == 0)
    else report_mismatch("an allowed write never reached the downstream port");
  endtask

  task automatic check_response(input logic [AXI_ID_WIDTH-1:0] id, input logic [1:0] resp,
                                input logic [AXI_USER_WIDTH-1:0] user);
    int idx;
    idx = -1;
    for (int i = 0; i < exp_id_q.size(); i++) begin
      if (idx < 0 && exp_id_q[i] == id)
        idx = i;
    end
    assert (idx >= 0)
    else report_mismatch($sformatf("response with unexpected or repeated id %0h", id));
    assert (resp == exp_resp_q[idx])
    else report_mismatch($sformatf("id %0h bresp %0d, expected %0d", id, resp, exp_resp_q[idx]));
    assert (user == '0)
    else report_mismatch($sformatf("id %0h buser %0h, expected 0", id, user));
    exp_id_q.delete(idx);
    exp_resp_q.delete(idx);
  endtask

  always @(posedge axi4_aclk) begin
    if (axi4_arstn && s_bvalid_o && s_bready_i)
      check_response(s_bid_o, s_bresp_o, s_buser_o);
  end

  // upstream bready drops low for random stretches in the back-pressure test
  always @(posedge axi4_aclk) begin
    if (!bp_mode) begin
      s_bready_i <= 1'b1;
    end else if (stretch == 0) begin
      s_bready_i <= ~s_bready_i;
      stretch <= lcg_next() % 5;
    end else begin
      stretch <= stretch - 1;
    end
  end

  // downstream memory model
  always @(posedge axi4_aclk) begin
    if (m_awvalid_o && m_awready_i) begin
      assert (fwd_id_q.size() > 0)
      else report_mismatch($sformatf("write to %h forwarded, should be dropped", m_awaddr_o));
      assert (m_awid_o == fwd_id_q[0] && m_awaddr_o == fwd_addr_q[0] &&
              m_awuser_o == fwd_user_q[0])
      else report_mismatch($sformatf(
        "m_aw id %0h addr %h user %h, expected id %0h addr %h user %h",
        m_awid_o, m_awaddr_o, m_awuser_o, fwd_id_q[0], fwd_addr_q[0], fwd_user_q[0]));
      aw_seen = 1'b1;
    end
    if (m_wvalid_o && m_wready_i) begin
      assert (fwd_data_q.size() > 0)
      else report_mismatch("data beat forwarded for a write that should be dropped");
      assert (m_wdata_o == fwd_data_q[0] && m_wstrb_o == fwd_strb_q[0])
      else report_mismatch($sformatf("m_w data %h strb %h, expected data %h strb %h",
                                     m_wdata_o, m_wstrb_o, fwd_data_q[0], fwd_strb_q[0]));
      w_seen = 1'b1;
    end
    if (aw_seen && w_seen) begin
      pend_id_q.push_back(fwd_id_q.pop_front());
      void'(fwd_addr_q.pop_front());
      void'(fwd_user_q.pop_front());
      void'(fwd_data_q.pop_front());
      void'(fwd_strb_q.pop_front());
      aw_seen = 1'b0;
      w_seen = 1'b0;
    end
    if (m_bvalid_i && !m_bready_o) begin
      m_bvalid_i <= 1'b1;
    end else if (pend_id_q.size() > 0 && b_delay == 0) begin
      next_bid = pend_id_q.pop_front();
      m_bvalid_i <= 1'b1;
      m_bid_i    <= next_bid;
      b_delay    <= lcg_next() % 6;
    end else begin
      m_bvalid_i <= 1'b0;
      if (b_delay != 0)
        b_delay <= b_delay - 1;
    end
  end

  task automatic allowed_write_forwarded();
    do_write(8'h11, 32'h1000_0040, 1'b0);
    do_write(8'h12, 32'h1000_0FFC, 1'b1);
    wait_responses();
  endtask

  task automatic unmapped_write_dropped();
    do_write(8'h21, 32'h3000_0000, 1'b0);
    do_write(8'h22, 32'h0FFF_FFFC, 1'b1);
    wait_responses();
  endtask

  task automatic protected_write_dropped();
    do_write(8'h31, 32'h2000_0040, 1'b0);
    do_write(8'h32, 32'h2000_0080, 1'b1);
    wait_responses();
  endtask

  task automatic reconfig_changes_outcome();
    configure_region(1, 32'h2000_0000, 32'h2000_0FFF, 1'b1, 1'b1);
    do_write(8'h41, 32'h2000_0040, 1'b0);
    wait_responses();
    configure_region(0, 32'h1000_0000, 32'h1000_0FFF, 1'b0, 1'b1);
    do_write(8'h42, 32'h1000_0040, 1'b1);
    wait_responses();
  endtask

  task automatic responses_under_backpressure();
    logic [31:0] addrs [5];
    logic [31:0] r;
    addrs[0] = 32'h1000_0100;
    addrs[1] = 32'h1000_0900;
    addrs[2] = 32'h2000_0200;
    addrs[3] = 32'h5000_0000;
    addrs[4] = 32'h2000_0FFC;
    // region 2 is read-only but overlaps writable region 0
    configure_region(0, 32'h1000_0000, 32'h1000_0FFF, 1'b1, 1'b1);
    configure_region(1, 32'h2000_0000, 32'h2000_0FFF, 1'b1, 1'b0);
    configure_region(2, 32'h1000_0800, 32'h1000_0FFF, 1'b1, 1'b0);
    bp_mode = 1'b1;
    for (int i = 0; i < 16; i++) begin
      r = lcg_next();
      do_write(8'h80 + 8'(i), addrs[r[7:4] % 5], r[12]);
    end
    wait_responses();
    bp_mode = 1'b0;
  endtask

  initial begin
    axi4_aclk      = 1'b0;
    axi4_arstn     = 1'b0;
    s_awid_i       = '0;
    s_awaddr_i     = '0;
    s_awuser_i     = '0;
    s_awvalid_i    = 1'b0;
    s_wdata_i      = '0;
    s_wstrb_i      = '0;
    s_wvalid_i     = 1'b0;
    s_bready_i     = 1'b1;
    m_awready_i    = 1'b1;
    m_wready_i     = 1'b1;
    m_bid_i        = '0;
    m_bresp_i      = RESP_OKAY;
    m_buser_i      = '0;
    m_bvalid_i     = 1'b0;
    cfg_we_i       = 1'b0;
    cfg_idx_i      = '0;
    cfg_base_i     = '0;
    cfg_last_i     = '0;
    cfg_valid_i    = 1'b0;
    cfg_writable_i = 1'b0;
    ref_valid      = '0;
    ref_wr         = '0;
    aw_seen        = 1'b0;
    w_seen         = 1'b0;
    b_delay        = 0;
    stretch        = 0;
    bp_mode        = 1'b0;
    repeat (5) @(posedge axi4_aclk);
    axi4_arstn <= 1'b1;
    configure_region(0, 32'h1000_0000, 32'h1000_0FFF, 1'b1, 1'b1);
    configure_region(1, 32'h2000_0000, 32'h2000_0FFF, 1'b1, 1'b0);
    allowed_write_forwarded();
    unmapped_write_dropped();
    protected_write_dropped();
    reconfig_changes_outcome();
    responses_under_backpressure();
    repeat (2) @(posedge axi4_aclk);
    if (uut.u_b_sender.u_chk.fail_count == 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      $display("bound B-channel assertions reported %0d errors",
               uut.u_b_sender.u_chk.fail_count);
      stop_with_failure();
    end
  end

endmodule

// File: sim.f
src/axi_defs_pkg.sv
src/remap_pkg.sv
src/axi_b_if.sv
src/region_table.sv
src/write_filter.sv
src/meta_fifo.sv
src/axi4_b_sender.sv
src/wr_remap_top.sv
test/b_sender_chk.sv
test/tb_wr_remap.sv
